//--- vlog.f
+incdir+testbench
hdl/pipePkg.sv
hdl/stageIf.sv
hdl/instructionDecoder.sv
hdl/registerFile.sv
hdl/idExReg.sv
hdl/executeStage.sv
hdl/decodeExecuteTop.sv
testbench/decodeExecuteTb.sv

//--- Makefile
# Verilator build and run for the decode-to-execute testbench.

TOP ?= decodeExecuteTb
VERILATOR ?= verilator
LOG ?= sim.log
FILELIST ?= vlog.f
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "Variables: TOP VERILATOR LOG FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/decodeExecuteTests.svh
// Add, sub, xor, andn by function code. Sub is B minus A.
function automatic word_t aluRef(logic [1:0] funct, word_t a, word_t b);
	case (funct)
		2'd0: return a + b;
		2'd1: return b - a;
		2'd2: return a ^ b;
		default: return a & ~b;
	endcase
endfunction

task automatic writeReg(regSel_t sel, word_t data);
	wbEn = 1'b1;
	wbSel = sel;
	wbData = data;
	stepClock();
	wbEn = 1'b0;
	regModel[sel] = data;
endtask

// Results of the issued instruction are visible after one edge.
task automatic issue(word_t ins, word_t pc);
	instr = ins;
	pcAdd2 = pc;
	stepClock();
endtask

task automatic resetBubble();
	startTest("resetBubble");
	for (int i = 0; i < resetCycles; i++) begin
		instr = i[0] ? {5'b11111, 11'h010} : {jal, 11'h010};	// Jump or error if not a bubble.
		stepClock();
		checkCtrl("ctrlOut in reset", '0, ctrlOut);
		checkBit("errOut in reset", 1'b0, errOut);
		checkBit("takeBranch in reset", 1'b0, takeBranch);
	end
	reset = 1'b0;
	issue({nop, 11'h000}, 16'h0002);
	checkCtrl("ctrlOut after reset", '0, ctrlOut);
	checkBit("errOut after reset", 1'b0, errOut);
	checkBit("takeBranch after reset", 1'b0, takeBranch);
	endTest();
endtask

task automatic aluOps();
	opcode_t immOps [4] = '{addi, subi, xori, andni};
	regSel_t rs;
	regSel_t rt;
	regSel_t rd;
	logic [4:0] imm;
	word_t immVal;
	startTest("aluOps");
	for (int i = 0; i < numRegs; i++) begin
		writeReg(regSel_t'(i), word_t'(nextRandom()));
	end
	for (int k = 0; k < 8; k++) begin
		rs = regSel_t'(nextRandom());
		rt = regSel_t'(nextRandom());
		rd = regSel_t'(nextRandom());
		imm = 5'(nextRandom());
		issue({rFormat, rs, rt, rd, 2'(k)}, 16'h0100);
		checkWord("rFormat aluResult", aluRef(2'(k), regModel[rs], regModel[rt]), aluResult);
		checkSel("rFormat dest", rd, writeRegSelOut);
		checkBit("rFormat RegWrite", 1'b1, ctrlOut[ctrlRegWriteBit]);
		immVal = (k % 4 < 2) ? {{11{imm[4]}}, imm} : {11'b0, imm};	// xori, andni zero extend.
		issue({immOps[k % 4], rs, rd, imm}, 16'h0100);
		checkWord("immediate aluResult", aluRef(2'(k), regModel[rs], immVal), aluResult);
		checkSel("immediate dest", rd, writeRegSelOut);
		checkBit("immediate RegWrite", 1'b1, ctrlOut[ctrlRegWriteBit]);
	end
	endTest();
endtask

task automatic memoryOps();
	opcode_t op;
	regSel_t rs;
	regSel_t rt;
	logic [4:0] imm;
	startTest("memoryOps");
	for (int k = 0; k < 4; k++) begin
		op = k[0] ? st : ld;
		rs = regSel_t'(nextRandom());
		rt = regSel_t'(nextRandom());
		imm = 5'(nextRandom());
		issue({op, rs, rt, imm}, 16'h0200);
		checkWord("address", regModel[rs] + {{11{imm[4]}}, imm}, aluResult);
		checkWord("storeData", regModel[rt], storeData);
		checkBit("DMemEn", 1'b1, ctrlOut[ctrlDMemEnBit]);
		checkBit("DMemWrite", k[0], ctrlOut[ctrlDMemWriteBit]);
		checkBit("DMemDump", 1'b0, ctrlOut[ctrlDMemDumpBit]);
		checkBit("MemToReg", !k[0], ctrlOut[ctrlMemToRegBit]);
		checkBit("RegWrite", !k[0], ctrlOut[ctrlRegWriteBit]);
	end
	endTest();
endtask

task automatic branches();
	opcode_t op;
	regSel_t rs;
	logic [7:0] off;
	word_t pc;
	startTest("branches");
	writeReg(3'd1, 16'h0000);
	writeReg(3'd2, word_t'(nextRandom()) | 16'h0001);
	for (int k = 0; k < 4; k++) begin
		op = k[0] ? bnez : beqz;
		rs = k[1] ? 3'd2 : 3'd1;
		off = 8'(nextRandom());
		pc = word_t'(nextRandom()) & 16'hfffe;
		issue({op, rs, off}, pc);
		checkBit("takeBranch", k[0] ? regModel[rs] != '0 : regModel[rs] == '0, takeBranch);
		checkWord("branchTarget", pc + {{8{off[7]}}, off}, branchTarget);
	end
	endTest();
endtask

task automatic jumps();
	opcode_t op;
	logic [10:0] off;
	word_t pc;
	startTest("jumps");
	for (int k = 0; k < 4; k++) begin
		op = k[0] ? jal : j;
		off = 11'(nextRandom());
		pc = word_t'(nextRandom()) & 16'hfffe;
		issue({op, off}, pc);
		checkBit("takeBranch", 1'b1, takeBranch);
		checkWord("branchTarget", pc + {{5{off[10]}}, off}, branchTarget);
		checkBit("RegWrite", k[0], ctrlOut[ctrlRegWriteBit]);
		if (k[0]) begin
			checkWord("linkData", pc, linkData);
			checkSel("link dest", 3'd7, writeRegSelOut);
		end
	end
	endTest();
endtask

task automatic illegalOpcode();
	logic [4:0] badOps [2] = '{5'b11111, 5'b00010};
	startTest("illegalOpcode");
	for (int k = 0; k < 2; k++) begin
		issue({badOps[k], 11'h5a5}, 16'h0300);
		checkBit("errOut", 1'b1, errOut);
		checkCtrl("ctrlOut", '0, ctrlOut);
		reset = 1'b1;
		stepClock();
		checkBit("errOut in reset", 1'b0, errOut);
		reset = 1'b0;
		for (int i = 0; i < numRegs; i++) begin
			regModel[i] = '0;
		end
	end
	endTest();
endtask

//--- testbench/decodeExecuteTb.sv
`timescale 1ns/1ps

module decodeExecuteTb import pipePkg::*; ();

	localparam int clkPeriod = 40;
	localparam int driveDelay = 2;
	localparam int resetCycles = 4;
	localparam int maxCycles = 600;		// Well above the length of all tests.

	logic clk;
	logic reset;
	word_t instr;
	word_t pcAdd2;
	logic wbEn;
	regSel_t wbSel;
	word_t wbData;
	ctrlWord_t ctrlOut;
	regSel_t writeRegSelOut;
	logic errOut;
	word_t aluResult;
	word_t storeData;
	word_t branchTarget;
	logic takeBranch;
	word_t linkData;

	word_t regModel [numRegs];		// Mirror of the register file.
	logic [31:0] rngState = 32'hec9c;
	string curTest;
	int testErrors = 0;
	int errorCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int cycleCount = 0;

	decodeExecuteTop UUT (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.pcAdd2(pcAdd2),
		.wbEn(wbEn),
		.wbSel(wbSel),
		.wbData(wbData),
		.ctrlOut(ctrlOut),
		.writeRegSelOut(writeRegSelOut),
		.errOut(errOut),
		.aluResult(aluResult),
		.storeData(storeData),
		.branchTarget(branchTarget),
		.takeBranch(takeBranch),
		.linkData(linkData)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= maxCycles) begin
			$display("Timeout: the run did not finish within %0d cycles", maxCycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	task automatic stepClock();
		@(posedge clk);
		#driveDelay;
	endtask

	task automatic startTest(string name);
		curTest = name;
		testErrors = 0;
	endtask

	task automatic endTest();
		testsRun++;
		if (testErrors != 0) begin
			testsFailed++;
		end
		$display("%-14s %s, %0d mismatches", curTest, testErrors == 0 ? "ok" : "bad", testErrors);
	endtask

	task automatic noteMismatch();
		testErrors++;
		errorCount++;
	endtask

	task automatic checkWord(string what, word_t expected, word_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s %s: expected %h, actual %h", curTest, what, expected, actual);
			noteMismatch();
		end
	endtask

	task automatic checkCtrl(string what, ctrlWord_t expected, ctrlWord_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s %s: expected %h, actual %h", curTest, what, expected, actual);
			noteMismatch();
		end
	endtask

	task automatic checkBit(string what, logic expected, logic actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s %s: expected %b, actual %b", curTest, what, expected, actual);
			noteMismatch();
		end
	endtask

	task automatic checkSel(string what, regSel_t expected, regSel_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s %s: expected %0d, actual %0d", curTest, what, expected, actual);
			noteMismatch();
		end
	endtask

	`include "decodeExecuteTests.svh"

	initial begin
		reset = 1'b1;
		instr = '0;
		pcAdd2 = '0;
		wbEn = 1'b0;
		wbSel = '0;
		wbData = '0;
		for (int i = 0; i < numRegs; i++) begin
			regModel[i] = '0;
		end
		resetBubble();
		aluOps();
		memoryOps();
		branches();
		jumps();
		illegalOpcode();
		$display("Summary: %0d tests, %0d failed, %0d mismatches", testsRun, testsFailed,
			errorCount);
		if (errorCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- hdl/decodeExecuteTop.sv
`timescale 1ns/1ps

module decodeExecuteTop import pipePkg::*; (
	input logic clk,
	input logic reset,
	input word_t instr,
	input word_t pcAdd2,
	input logic wbEn,
	input regSel_t wbSel,
	input word_t wbData,
	output ctrlWord_t ctrlOut,
	output regSel_t writeRegSelOut,
	output logic errOut,
	output word_t aluResult,
	output word_t storeData,
	output word_t branchTarget,
	output logic takeBranch,
	output word_t linkData
);

	stageIf decodeBus ();
	stageIf execBus ();

	regSel_t readSel1;
	regSel_t readSel2;

	instructionDecoder decoder (
		.instr(instr),
		.ctrl(decodeBus.ctrl),
		.writeRegSel(decodeBus.writeRegSel),
		.readSel1(readSel1),
		.readSel2(readSel2),
		.immExt(decodeBus.immExt),
		.illegal(decodeBus.err)
	);

	registerFile regFile (
		.clk(clk),
		.reset(reset),
		.readSel1(readSel1),
		.readSel2(readSel2),
		.readData1(decodeBus.readData1),
		.readData2(decodeBus.readData2),
		.writeEn(wbEn),
		.writeSel(wbSel),
		.writeData(wbData)
	);

	assign decodeBus.pcAdd2 = pcAdd2;
	assign decodeBus.bubble = reset;		// Captured in reset becomes a bubble.

	idExReg pipeReg (
		.clk(clk),
		.reset(reset),
		.in(decodeBus.sink),
		.out(execBus.source)
	);

	executeStage execute (
		.in(execBus.sink),
		.aluResult(aluResult),
		.storeData(storeData),
		.branchTarget(branchTarget),
		.takeBranch(takeBranch)
	);

	assign ctrlOut = execBus.ctrl;
	assign writeRegSelOut = execBus.writeRegSel;
	assign errOut = execBus.err;
	assign linkData = execBus.pcAdd2;

endmodule

//--- hdl/executeStage.sv
`timescale 1ns/1ps

module executeStage import pipePkg::*; (
	stageIf.sink in,
	output word_t aluResult,
	output word_t storeData,
	output word_t branchTarget,
	output logic takeBranch
);

	aluCtrl_t aluOp;
	word_t opA;
	word_t opB;
	logic isZero;
	logic condMet;

	assign aluOp = aluCtrl_t'(in.ctrl[ctrlAluCtrlHi:ctrlAluCtrlLo]);
	assign opA = in.readData1;
	assign opB = in.ctrl[ctrlAluSrc2Bit] ? in.immExt : in.readData2;

	always_comb begin
		case (aluOp)
			aluAdd: aluResult = opA + opB;
			aluSub: aluResult = opB - opA;	// Reversed operands.
			aluXor: aluResult = opA ^ opB;
			aluAndn: aluResult = opA & ~opB;
			aluPassB: aluResult = opB;
			default: aluResult = '0;
		endcase
	end

	assign branchTarget = (in.ctrl[ctrlPcImmBit] || in.ctrl[ctrlJumpBit])
		? in.pcAdd2 + in.immExt : in.pcAdd2;

	assign isZero = (in.readData1 == '0);
	assign condMet = in.ctrl[ctrlOpLo] ? !isZero : isZero;	// Bit 0 set is bnez.
	assign takeBranch = in.ctrl[ctrlJumpBit] || (in.ctrl[ctrlPcSrcBit] && condMet);

	assign storeData = in.readData2;

endmodule

//--- hdl/idExReg.sv
`timescale 1ns/1ps

module idExReg import pipePkg::*; (
	input logic clk,
	input logic reset,
	stageIf.sink in,
	stageIf.source out
);

	logic errQ;

	// Control and marker state.
	always_ff @(posedge clk) begin
		if (reset) begin
			out.ctrl <= '0;
			out.bubble <= 1'b1;
			errQ <= 1'b0;
		end else begin
			out.ctrl <= in.bubble ? '0 : in.ctrl;
			out.bubble <= in.bubble;
			errQ <= in.err;
		end
	end

	// Payload loads every cycle.
	always_ff @(posedge clk) begin
		out.pcAdd2 <= in.pcAdd2;
		out.readData1 <= in.readData1;
		out.readData2 <= in.readData2;
		out.immExt <= in.immExt;
		out.writeRegSel <= in.writeRegSel;
	end

	assign out.err = errQ & ~out.bubble;		// Masked in a bubble.

	bubbleIsInert: assert property (
		@(posedge clk)
		out.bubble |-> !(out.ctrl[ctrlRegWriteBit] || out.ctrl[ctrlDMemEnBit])
	) else $error("bubble carries a register or memory write");

endmodule

//--- hdl/registerFile.sv
`timescale 1ns/1ps

module registerFile import pipePkg::*; (
	input logic clk,
	input logic reset,
	input regSel_t readSel1,
	input regSel_t readSel2,
	output word_t readData1,
	output word_t readData2,
	input logic writeEn,
	input regSel_t writeSel,
	input word_t writeData
);

	word_t regs [numRegs];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeSel] <= writeData;
		end
	end

	// Without a bypass a same-cycle read sees the old value.
	assign readData1 = regs[readSel1];
	assign readData2 = regs[readSel2];

	writeSelKnown: assert property (
		@(posedge clk) disable iff (reset)
		writeEn |-> !$isunknown(writeSel)
	) else $error("write enabled with unknown register select");

endmodule

//--- hdl/instructionDecoder.sv
`timescale 1ns/1ps

module instructionDecoder import pipePkg::*; (
	input word_t instr,
	output ctrlWord_t ctrl,
	output regSel_t writeRegSel,
	output regSel_t readSel1,
	output regSel_t readSel2,
	output word_t immExt,
	output logic illegal
);

	opcode_t opcode;
	aluCtrl_t aluOp;

	assign opcode = opcode_t'(instr[15:11]);
	assign readSel1 = instr[10:8];			// Rs.
	assign readSel2 = instr[7:5];			// Rt, or store data.

	assign illegal = !(opcode inside {halt, nop, j, jal, addi, subi, xori, andni,
		beqz, bnez, st, ld, rFormat});

	always_comb begin
		ctrl = '0;
		aluOp = aluAdd;
		case (opcode)
			addi, subi, xori, andni: begin
				ctrl[ctrlAluSrc2Bit] = 1'b1;
				ctrl[ctrlRegWriteBit] = 1'b1;
				aluOp = aluCtrl_t'({2'b00, opcode[1:0]});	// Same order as funct.
			end
			rFormat: begin
				ctrl[ctrlRegWriteBit] = 1'b1;
				aluOp = aluCtrl_t'({2'b00, instr[1:0]});
			end
			ld: begin
				ctrl[ctrlAluSrc2Bit] = 1'b1;
				ctrl[ctrlDMemEnBit] = 1'b1;
				ctrl[ctrlMemToRegBit] = 1'b1;
				ctrl[ctrlRegWriteBit] = 1'b1;
			end
			st: begin
				ctrl[ctrlAluSrc2Bit] = 1'b1;
				ctrl[ctrlDMemEnBit] = 1'b1;
				ctrl[ctrlDMemWriteBit] = 1'b1;
			end
			beqz, bnez: begin
				ctrl[ctrlPcImmBit] = 1'b1;
				ctrl[ctrlPcSrcBit] = 1'b1;
				ctrl[ctrlOpHi:ctrlOpLo] = opcode[1:0];
			end
			j, jal: begin
				ctrl[ctrlAluSrc2Bit] = 1'b1;
				ctrl[ctrlPcImmBit] = 1'b1;
				ctrl[ctrlJumpBit] = 1'b1;
				ctrl[ctrlWriteDataSelBit] = (opcode == jal);	// Write back PC+2.
				ctrl[ctrlRegWriteBit] = (opcode == jal);
				aluOp = aluPassB;
			end
			halt: ctrl[ctrlDMemDumpBit] = 1'b1;
			default: ;
		endcase
		ctrl[ctrlAluCtrlHi:ctrlAluCtrlLo] = aluOp;
	end

	always_comb begin
		case (opcode)
			rFormat: writeRegSel = instr[4:2];
			addi, subi, xori, andni, ld: writeRegSel = instr[7:5];
			jal: writeRegSel = regSel_t'(numRegs - 1);	// Link register.
			default: writeRegSel = '0;
		endcase
	end

	always_comb begin
		case (opcode)
			addi, subi, ld, st: immExt = {{11{instr[4]}}, instr[4:0]};
			xori, andni: immExt = {11'b0, instr[4:0]};
			beqz, bnez: immExt = {{8{instr[7]}}, instr[7:0]};
			j, jal: immExt = {{5{instr[10]}}, instr[10:0]};
			default: immExt = '0;
		endcase
	end

	// The legality list and the control case must agree.
	always_comb begin
		assert final (!illegal || ctrl == '0)
			else $error("control word set for illegal opcode %b", instr[15:11]);
	end

endmodule

//--- hdl/stageIf.sv
`timescale 1ns/1ps

interface stageIf import pipePkg::*; ();

	ctrlWord_t ctrl;
	word_t pcAdd2;
	word_t readData1;
	word_t readData2;
	word_t immExt;
	regSel_t writeRegSel;
	logic bubble;			// Slot holds no instruction.
	logic err;

	modport source (
		output ctrl, pcAdd2, readData1, readData2, immExt,
		output writeRegSel, bubble, err
	);

	modport sink (
		input ctrl, pcAdd2, readData1, readData2, immExt,
		input writeRegSel, bubble, err
	);

endinterface

//--- hdl/pipePkg.sv
package pipePkg;

	localparam int dataWidth = 16;
	localparam int regSelWidth = 3;
	localparam int numRegs = 8;
	localparam int opcodeWidth = 5;
	localparam int aluCtrlWidth = 4;
	localparam int ctrlWidth = 16;

	// Control word bit positions.
	localparam int ctrlAluSrc2Bit = 15;
	localparam int ctrlAluCtrlHi = 14;
	localparam int ctrlAluCtrlLo = 11;
	localparam int ctrlPcImmBit = 10;
	localparam int ctrlPcSrcBit = 9;
	localparam int ctrlJumpBit = 8;
	localparam int ctrlOpHi = 7;
	localparam int ctrlOpLo = 6;
	localparam int ctrlDMemEnBit = 5;
	localparam int ctrlDMemWriteBit = 4;
	localparam int ctrlDMemDumpBit = 3;
	localparam int ctrlMemToRegBit = 2;
	localparam int ctrlWriteDataSelBit = 1;
	localparam int ctrlRegWriteBit = 0;

	typedef logic [dataWidth-1:0] word_t;
	typedef logic [regSelWidth-1:0] regSel_t;
	typedef logic [ctrlWidth-1:0] ctrlWord_t;

	typedef enum logic [opcodeWidth-1:0] {
		halt = 5'b00000,
		nop = 5'b00001,
		j = 5'b00100,
		jal = 5'b00110,
		addi = 5'b01000,
		subi = 5'b01001,
		xori = 5'b01010,
		andni = 5'b01011,
		beqz = 5'b01100,		// Bit 0 clear tests for zero.
		bnez = 5'b01101,
		st = 5'b10000,
		ld = 5'b10001,
		rFormat = 5'b11011		// Function code in bits 1:0.
	} opcode_t;

	typedef enum logic [aluCtrlWidth-1:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluXor = 4'd2,
		aluAndn = 4'd3,
		aluPassB = 4'd4
	} aluCtrl_t;

endpackage
